// ==== hw/csa_pkg.sv ====
package csa_pkg;

	localparam int csa_data_w = 32;
	localparam int csa_addr_w = 10;

	localparam int csa_job_words = 5;
	localparam int csa_result_words = 7;

	localparam logic [csa_addr_w-1:0] reg_channel = 'd0;
	localparam logic [csa_addr_w-1:0] reg_in_valid = 'd1;
	localparam logic [csa_addr_w-1:0] reg_in_data_0 = 'd2; // up to 6
	localparam logic [csa_addr_w-1:0] reg_out_valid = 'd7;
	localparam logic [csa_addr_w-1:0] reg_out_data_0 = 'd8; // up to 14
	localparam logic [csa_addr_w-1:0] reg_catch_index = 'd15;
	localparam logic [csa_addr_w-1:0] reg_catch_low = 'd16;
	localparam logic [csa_addr_w-1:0] reg_catch_high = 'd17;
	localparam logic [csa_addr_w-1:0] reg_clear = 'd18;

	typedef struct packed {
		logic [csa_data_w-1:0] block;
		logic [2*csa_data_w-1:0] key;
		logic [csa_data_w-1:0] times;
		logic [csa_data_w-1:0] times_start;
	} csa_job_t;

	typedef struct packed {
		csa_job_t job;
		logic [2*csa_data_w-1:0] out;
	} csa_result_t;

	typedef logic [63:0] csa_catch_t;

	// word order on the bus is block, key low, key high, times, times_start
	function automatic logic [csa_data_w-1:0] csa_job_word(csa_job_t job, logic [2:0] idx);
		case (idx)
			3'd0: return job.block;
			3'd1: return job.key[csa_data_w-1:0];
			3'd2: return job.key[2*csa_data_w-1:csa_data_w];
			3'd3: return job.times;
			default: return job.times_start;
		endcase
	endfunction

	function automatic logic [csa_data_w-1:0] csa_result_word(csa_result_t res, logic [2:0] idx);
		case (idx)
			3'd5: return res.out[csa_data_w-1:0];
			3'd6: return res.out[2*csa_data_w-1:csa_data_w];
			default: return csa_job_word(res.job, idx);
		endcase
	endfunction

endpackage

// ==== hw/csa_catch_hist.sv ====
`timescale 1ns/1ps

module csa_catch_hist (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic hit_i,
	input logic [7:0] bin_i,
	input logic clear_i,
	input logic [7:0] sel_i,
	output csa_pkg::csa_catch_t count_o
);

	import csa_pkg::*;

	csa_catch_t mem_q [256];

	assign count_o = mem_q[sel_i];

	// a clear wins over a hit in the same cycle
	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n || clear_i) begin
			for (int i = 0; i < 256; i++) begin
				mem_q[i] <= '0;
			end
		end else if (hit_i) begin
			mem_q[bin_i] <= mem_q[bin_i] + 1'b1;
		end
	end

endmodule

// ==== hw/csa_trial_unit.sv ====
`timescale 1ns/1ps

module csa_trial_unit (
	input logic axi_mm_clk,
	input logic rst_n,
	input csa_pkg::csa_job_t job_i,
	input logic wen_i,
	output logic full_o,
	output logic ready_o,
	input logic take_i,
	output csa_pkg::csa_result_t result_o
);

	import csa_pkg::*;

	logic running_q;
	logic [csa_data_w-1:0] k_q;
	logic [2*csa_data_w-1:0] acc_q;
	csa_job_t job_q;
	logic last_trial;

	assign last_trial = (k_q == job_q.times);
	assign result_o = '{job: job_q, out: acc_q};

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			full_o <= 1'b0;
			ready_o <= 1'b0;
			running_q <= 1'b0;
		end else if (wen_i) begin
			full_o <= 1'b1;
			ready_o <= 1'b0;
			running_q <= 1'b1;
		end else if (running_q && last_trial) begin
			running_q <= 1'b0;
			ready_o <= 1'b1;
		end else if (take_i) begin
			ready_o <= 1'b0;
			full_o <= 1'b0;
		end
	end

	// one trial per cycle, so the latency follows times
	always_ff @(posedge axi_mm_clk) begin
		if (wen_i) begin
			job_q <= job_i;
			acc_q <= job_i.key;
			k_q <= '0;
		end else if (running_q && !last_trial) begin
			acc_q <= {acc_q[2*csa_data_w-2:0], acc_q[2*csa_data_w-1]}
				^ {{csa_data_w{1'b0}}, job_q.block ^ (job_q.times_start + k_q)};
			k_q <= k_q + 1'b1;
		end
	end

	a_no_write_when_full: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		wen_i |-> !full_o);

	a_take_when_ready: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		take_i |-> ready_o);

endmodule

// ==== hw/csa_job_dispatch.sv ====
`timescale 1ns/1ps

module csa_job_dispatch #(
	parameter int unit_num = 4,
	localparam int idx_w = (unit_num > 1) ? $clog2(unit_num) : 1
) (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic in_ready_i,
	output logic in_ren_o,
	input logic [csa_pkg::csa_data_w-1:0] in_rdata_i,
	input logic [unit_num-1:0] unit_full_i,
	output csa_pkg::csa_job_t job_o,
	output logic [unit_num-1:0] job_wen_o,
	output logic disp_pulse_o,
	output logic [idx_w-1:0] disp_index_o
);

	import csa_pkg::*;

	typedef enum logic [3:0] {
		st_idle,
		st_pop,
		st_cap_block,
		st_cap_key_lo,
		st_cap_key_hi,
		st_cap_times,
		st_cap_start,
		st_wait_unit,
		st_write,
		st_advance
	} disp_state_t;

	disp_state_t state_q;
	logic [idx_w-1:0] idx_q;

	assign disp_index_o = idx_q;

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state_q <= st_idle;
			idx_q <= '0;
			in_ren_o <= 1'b0;
			job_wen_o <= '0;
			disp_pulse_o <= 1'b0;
		end else begin
			in_ren_o <= 1'b0;
			job_wen_o <= '0;
			disp_pulse_o <= 1'b0;
			case (state_q)
				st_idle: begin
					if (in_ready_i) begin
						in_ren_o <= 1'b1;
						state_q <= st_pop;
					end
				end
				st_pop: begin
					in_ren_o <= 1'b1;
					state_q <= st_cap_block;
				end
				st_cap_block: begin
					in_ren_o <= 1'b1;
					state_q <= st_cap_key_lo;
				end
				st_cap_key_lo: begin
					in_ren_o <= 1'b1;
					state_q <= st_cap_key_hi;
				end
				st_cap_key_hi: begin
					in_ren_o <= 1'b1; // fifth and last pop
					state_q <= st_cap_times;
				end
				st_cap_times: state_q <= st_cap_start;
				st_cap_start: state_q <= st_wait_unit;
				st_wait_unit: begin
					if (!unit_full_i[idx_q]) begin
						state_q <= st_write;
					end
				end
				st_write: begin
					job_wen_o[idx_q] <= 1'b1;
					disp_pulse_o <= 1'b1;
					state_q <= st_advance;
				end
				st_advance: begin
					idx_q <= (idx_q == idx_w'(unit_num - 1)) ? '0 : idx_q + 1'b1;
					state_q <= st_idle;
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	// fifo data shows up one cycle behind each pop
	always_ff @(posedge axi_mm_clk) begin
		case (state_q)
			st_cap_block: job_o.block <= in_rdata_i;
			st_cap_key_lo: job_o.key[csa_data_w-1:0] <= in_rdata_i;
			st_cap_key_hi: job_o.key[2*csa_data_w-1:csa_data_w] <= in_rdata_i;
			st_cap_times: job_o.times <= in_rdata_i;
			st_cap_start: job_o.times_start <= in_rdata_i;
			default: ;
		endcase
	end

	a_wen_onehot: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		$onehot0(job_wen_o) && ((job_wen_o & unit_full_i) == '0));

endmodule

// ==== hw/csa_result_collect.sv ====
`timescale 1ns/1ps

module csa_result_collect #(
	parameter int unit_num = 4,
	localparam int idx_w = (unit_num > 1) ? $clog2(unit_num) : 1
) (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic [unit_num-1:0] unit_ready_i,
	input csa_pkg::csa_result_t unit_result_i [unit_num],
	output logic [unit_num-1:0] unit_take_o,
	input logic out_full_i,
	output logic out_wen_o,
	output logic [csa_pkg::csa_data_w-1:0] out_wdata_o,
	output logic coll_pulse_o,
	output logic [idx_w-1:0] coll_index_o,
	output csa_pkg::csa_result_t coll_result_o,
	output logic hit_o,
	output logic [7:0] hit_bin_o
);

	import csa_pkg::*;

	typedef enum logic [2:0] {
		st_idle,
		st_take,
		st_wait_room,
		st_burst,
		st_advance
	} coll_state_t;

	coll_state_t state_q;
	logic [idx_w-1:0] idx_q;
	logic [2:0] word_q;
	csa_result_t res_q;

	assign coll_index_o = idx_q;
	assign coll_result_o = res_q;
	assign hit_bin_o = res_q.out[7:0];

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			state_q <= st_idle;
			idx_q <= '0;
			word_q <= '0;
			unit_take_o <= '0;
			out_wen_o <= 1'b0;
			coll_pulse_o <= 1'b0;
			hit_o <= 1'b0;
		end else begin
			unit_take_o <= '0;
			out_wen_o <= 1'b0;
			coll_pulse_o <= 1'b0;
			hit_o <= 1'b0;
			case (state_q)
				st_idle: begin
					if (unit_ready_i[idx_q]) begin
						state_q <= st_take;
					end
				end
				st_take: begin
					unit_take_o[idx_q] <= 1'b1;
					coll_pulse_o <= 1'b1;
					word_q <= '0;
					state_q <= st_wait_room;
				end
				st_wait_room: begin
					// room is checked once, the host guarantees the whole burst
					if (!out_full_i) begin
						out_wen_o <= 1'b1;
						word_q <= 3'd1;
						state_q <= st_burst;
					end
				end
				st_burst: begin
					out_wen_o <= 1'b1;
					hit_o <= (word_q == 3'd5);
					word_q <= word_q + 1'b1;
					if (word_q == 3'(csa_result_words - 1)) begin
						state_q <= st_advance;
					end
				end
				st_advance: begin
					idx_q <= (idx_q == idx_w'(unit_num - 1)) ? '0 : idx_q + 1'b1;
					state_q <= st_idle;
				end
				default: state_q <= st_idle;
			endcase
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (state_q == st_take) begin
			res_q <= unit_result_i[idx_q];
		end
		out_wdata_o <= csa_result_word(res_q, word_q); // only sampled with out_wen_o
	end

endmodule

// ==== hw/csa_regfile.sv ====
`timescale 1ns/1ps

module csa_regfile #(
	parameter int unit_num = 4,
	localparam int idx_w = (unit_num > 1) ? $clog2(unit_num) : 1
) (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wen_i,
	input logic [csa_pkg::csa_addr_w-1:0] waddr_i,
	input logic [csa_pkg::csa_data_w-1:0] wdata_i,
	input logic ren_i,
	input logic [csa_pkg::csa_addr_w-1:0] raddr_i,
	output logic [csa_pkg::csa_data_w-1:0] rdata_o,
	input logic disp_pulse_i,
	input logic [idx_w-1:0] disp_index_i,
	input csa_pkg::csa_job_t disp_job_i,
	input logic coll_pulse_i,
	input logic [idx_w-1:0] coll_index_i,
	input csa_pkg::csa_result_t coll_result_i,
	input csa_pkg::csa_catch_t count_i,
	output logic [7:0] bin_sel_o,
	output logic clear_o
);

	import csa_pkg::*;

	logic [idx_w-1:0] chan_q;
	logic in_valid_q;
	logic out_valid_q;
	logic [1:0] clr_q;
	logic chan_wr;
	csa_job_t in_mirror_q;
	csa_result_t out_mirror_q;
	logic [csa_addr_w-1:0] in_off;
	logic [csa_addr_w-1:0] out_off;

	assign chan_wr = wen_i && (waddr_i == reg_channel) && (wdata_i < csa_data_w'(unit_num));
	assign in_off = raddr_i - reg_in_data_0;
	assign out_off = raddr_i - reg_out_data_0;
	assign clear_o = |clr_q; // two cycles wide

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			chan_q <= '0;
			in_valid_q <= 1'b0;
			out_valid_q <= 1'b0;
			bin_sel_o <= '0;
			clr_q <= '0;
		end else begin
			clr_q <= {clr_q[0], wen_i && (waddr_i == reg_clear)};
			if (wen_i && (waddr_i == reg_catch_index)) begin
				bin_sel_o <= wdata_i[7:0];
			end
			if (chan_wr) begin
				chan_q <= wdata_i[idx_w-1:0];
				in_valid_q <= 1'b0; // a pulse for the old channel is dropped
				out_valid_q <= 1'b0;
			end else begin
				if (disp_pulse_i && (disp_index_i == chan_q)) begin
					in_valid_q <= 1'b1;
				end
				if (coll_pulse_i && (coll_index_i == chan_q)) begin
					out_valid_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!chan_wr && disp_pulse_i && (disp_index_i == chan_q)) begin
			in_mirror_q <= disp_job_i;
		end
		if (!chan_wr && coll_pulse_i && (coll_index_i == chan_q)) begin
			out_mirror_q <= coll_result_i;
		end
	end

	always_ff @(posedge axi_mm_clk) begin
		if (!rst_n) begin
			rdata_o <= '0;
		end else if (ren_i) begin
			case (raddr_i)
				reg_channel: rdata_o <= csa_data_w'(chan_q);
				reg_in_valid: rdata_o <= csa_data_w'(in_valid_q);
				reg_out_valid: rdata_o <= csa_data_w'(out_valid_q);
				reg_catch_index: rdata_o <= csa_data_w'(bin_sel_o);
				reg_catch_low: rdata_o <= count_i[csa_data_w-1:0];
				reg_catch_high: rdata_o <= count_i[2*csa_data_w-1:csa_data_w];
				default: begin
					if (in_off < csa_addr_w'(csa_job_words)) begin
						rdata_o <= csa_job_word(in_mirror_q, in_off[2:0]);
					end else if (out_off < csa_addr_w'(csa_result_words)) begin
						rdata_o <= csa_result_word(out_mirror_q, out_off[2:0]);
					end else begin
						rdata_o <= {16'hE000, {(16-csa_addr_w){1'b0}}, raddr_i};
					end
				end
			endcase
		end
	end

	a_chan_range: assert property (@(posedge axi_mm_clk) disable iff (!rst_n)
		chan_q < unit_num);

endmodule

// ==== hw/csa_brute_top.sv ====
`timescale 1ns/1ps

module csa_brute_top #(
	parameter int unit_num = 4,
	localparam int idx_w = (unit_num > 1) ? $clog2(unit_num) : 1
) (
	input logic axi_mm_clk,
	input logic rst_n,
	input logic wen_i,
	input logic [csa_pkg::csa_addr_w-1:0] waddr_i,
	input logic [csa_pkg::csa_data_w-1:0] wdata_i,
	input logic ren_i,
	input logic [csa_pkg::csa_addr_w-1:0] raddr_i,
	output logic [csa_pkg::csa_data_w-1:0] rdata_o,
	input logic in_ready_i,
	output logic in_ren_o,
	input logic [csa_pkg::csa_data_w-1:0] in_rdata_i,
	input logic out_full_i,
	output logic out_wen_o,
	output logic [csa_pkg::csa_data_w-1:0] out_wdata_o
);

	import csa_pkg::*;

	csa_job_t job;
	logic [unit_num-1:0] job_wen;
	logic [unit_num-1:0] unit_full;
	logic [unit_num-1:0] unit_ready;
	logic [unit_num-1:0] unit_take;
	csa_result_t unit_result [unit_num];
	logic disp_pulse;
	logic [idx_w-1:0] disp_index;
	logic coll_pulse;
	logic [idx_w-1:0] coll_index;
	csa_result_t coll_result;
	logic hit;
	logic [7:0] hit_bin;
	logic [7:0] bin_sel;
	logic clear;
	csa_catch_t count;

	csa_regfile #(.unit_num(unit_num)) u_regfile (
		.axi_mm_clk(axi_mm_clk), .rst_n(rst_n),
		.wen_i(wen_i), .waddr_i(waddr_i), .wdata_i(wdata_i),
		.ren_i(ren_i), .raddr_i(raddr_i), .rdata_o(rdata_o),
		.disp_pulse_i(disp_pulse), .disp_index_i(disp_index), .disp_job_i(job),
		.coll_pulse_i(coll_pulse), .coll_index_i(coll_index), .coll_result_i(coll_result),
		.count_i(count), .bin_sel_o(bin_sel), .clear_o(clear)
	);

	csa_job_dispatch #(.unit_num(unit_num)) u_dispatch (
		.axi_mm_clk(axi_mm_clk), .rst_n(rst_n),
		.in_ready_i(in_ready_i), .in_ren_o(in_ren_o), .in_rdata_i(in_rdata_i),
		.unit_full_i(unit_full), .job_o(job), .job_wen_o(job_wen),
		.disp_pulse_o(disp_pulse), .disp_index_o(disp_index)
	);

	for (genvar g = 0; g < unit_num; g++) begin : g_unit
		csa_trial_unit u_unit (
			.axi_mm_clk(axi_mm_clk), .rst_n(rst_n),
			.job_i(job), .wen_i(job_wen[g]), .full_o(unit_full[g]),
			.ready_o(unit_ready[g]), .take_i(unit_take[g]), .result_o(unit_result[g])
		);
	end

	csa_result_collect #(.unit_num(unit_num)) u_collect (
		.axi_mm_clk(axi_mm_clk), .rst_n(rst_n),
		.unit_ready_i(unit_ready), .unit_result_i(unit_result), .unit_take_o(unit_take),
		.out_full_i(out_full_i), .out_wen_o(out_wen_o), .out_wdata_o(out_wdata_o),
		.coll_pulse_o(coll_pulse), .coll_index_o(coll_index), .coll_result_o(coll_result),
		.hit_o(hit), .hit_bin_o(hit_bin)
	);

	csa_catch_hist u_hist (
		.axi_mm_clk(axi_mm_clk), .rst_n(rst_n),
		.hit_i(hit), .bin_i(hit_bin), .clear_i(clear),
		.sel_i(bin_sel), .count_o(count)
	);

endmodule

// ==== tests/csa_tb.sv ====
`timescale 1ns/1ps

module csa_tb;

	import csa_pkg::*;

	localparam int unit_num = 4;
	localparam int jobs_per_test = 12;
	localparam int timeout_cycles = 2 * jobs_per_test * 200 + 4000; // two bin sweeps take ~1600

	logic axi_mm_clk;
	logic rst_n;
	logic wen_i;
	logic [csa_addr_w-1:0] waddr_i;
	logic [csa_data_w-1:0] wdata_i;
	logic ren_i;
	logic [csa_addr_w-1:0] raddr_i;
	logic [csa_data_w-1:0] rdata_o;
	logic in_ready_i = 1'b0;
	logic in_ren_o;
	logic [csa_data_w-1:0] in_rdata_i = '0;
	logic out_full_i = 1'b0;
	logic out_wen_o;
	logic [csa_data_w-1:0] out_wdata_o;

	logic [csa_data_w-1:0] in_q[$];
	logic [csa_data_w-1:0] burst_q[$];
	csa_result_t exp_q[$];
	csa_result_t mirror_exp;
	logic pop_pend = 1'b0;
	logic bp_en = 1'b0;
	int hist_exp[256];
	int bursts_seen = 0;
	int jobs_sent = 0;
	int err_cnt = 0;
	int check_cnt = 0;
	int test_cnt = 0;
	int test_fail = 0;

	always #5 axi_mm_clk = ~axi_mm_clk;

	csa_brute_top #(.unit_num(unit_num)) u_dut (.*);

	// rotate-and-xor trial loop, one step per trial value
	function automatic csa_result_t csa_ref(csa_job_t job);
		logic [63:0] st;
		logic [31:0] trial;
		csa_result_t res;
		st = job.key;
		for (int unsigned k = 0; k < job.times; k++) begin
			trial = job.block ^ (job.times_start + k);
			st = {st[62:0], st[63]} ^ {32'h0, trial};
		end
		res.job = job;
		res.out = st;
		return res;
	endfunction

	function automatic logic [csa_data_w-1:0] result_word(csa_result_t res, int idx);
		case (idx)
			0: return res.job.block;
			1: return res.job.key[31:0];
			2: return res.job.key[63:32];
			3: return res.job.times;
			4: return res.job.times_start;
			5: return res.out[31:0];
			default: return res.out[63:32];
		endcase
	endfunction

	task automatic check_result(csa_result_t got, csa_result_t exp, string what);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_word(logic [csa_data_w-1:0] got, logic [csa_data_w-1:0] exp,
			string what);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("CHECK FAILED at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic check_count(csa_catch_t got, csa_catch_t exp, string what);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	// input FIFO, a pop shows its word one cycle after the read enable
	always @(negedge axi_mm_clk) begin
		if (pop_pend && in_q.size() > 0) begin
			in_rdata_i = in_q.pop_front();
		end
		pop_pend = rst_n && in_ren_o;
		in_ready_i = (in_q.size() >= 5);
	end

	// output FIFO and burst compare
	always @(negedge axi_mm_clk) begin : out_fifo
		csa_result_t got;
		out_full_i = bp_en ? ($urandom % 3 == 0) : 1'b0;
		if (rst_n && out_wen_o) begin
			burst_q.push_back(out_wdata_o);
		end
		if (burst_q.size() == 7) begin
			got.job.block = burst_q[0];
			got.job.key = {burst_q[2], burst_q[1]};
			got.job.times = burst_q[3];
			got.job.times_start = burst_q[4];
			got.out = {burst_q[6], burst_q[5]};
			if (exp_q.size() == 0) begin
				err_cnt++;
				$display("burst %0d arrived with no job outstanding", bursts_seen);
			end else begin
				check_result(got, exp_q.pop_front(), $sformatf("burst %0d", bursts_seen));
			end
			bursts_seen++;
			burst_q.delete();
		end
	end

	// each job enters the input FIFO as five words in struct order
	task automatic queue_jobs(int n);
		csa_job_t job;
		csa_result_t res;
		for (int i = 0; i < n; i++) begin
			job.block = $urandom;
			job.key = {$urandom, $urandom};
			job.times = $urandom % 16;
			job.times_start = $urandom;
			res = csa_ref(job);
			in_q.push_back(job.block);
			in_q.push_back(job.key[31:0]);
			in_q.push_back(job.key[63:32]);
			in_q.push_back(job.times);
			in_q.push_back(job.times_start);
			exp_q.push_back(res);
			hist_exp[res.out[7:0]]++;
			if (jobs_sent % unit_num == 2) begin
				mirror_exp = res;
			end
			jobs_sent++;
		end
	endtask

	task automatic wait_bursts(int target);
		int cycles;
		cycles = 0;
		while (bursts_seen < target && cycles < jobs_per_test * 200) begin
			@(negedge axi_mm_clk);
			cycles++;
		end
		if (bursts_seen < target) begin
			err_cnt++;
			$display("only %0d of %0d bursts arrived in time", bursts_seen, target);
		end
	endtask

	task automatic write_reg(logic [csa_addr_w-1:0] addr, logic [csa_data_w-1:0] data);
		wen_i = 1'b1;
		waddr_i = addr;
		wdata_i = data;
		@(negedge axi_mm_clk);
		wen_i = 1'b0;
	endtask

	task automatic read_reg(logic [csa_addr_w-1:0] addr, output logic [csa_data_w-1:0] data);
		ren_i = 1'b1;
		raddr_i = addr;
		@(negedge axi_mm_clk);
		ren_i = 1'b0;
		data = rdata_o;
	endtask

	task automatic read_count(int bin, output csa_catch_t cnt);
		logic [csa_data_w-1:0] lo;
		logic [csa_data_w-1:0] hi;
		write_reg(reg_catch_index, bin);
		read_reg(reg_catch_low, lo);
		read_reg(reg_catch_high, hi);
		cnt = {hi, lo};
	endtask

	task automatic finish_test(string name, int errs_before);
		test_cnt++;
		if (err_cnt == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			test_fail++;
			$display("test %s: %0d errors", name, err_cnt - errs_before);
		end
	endtask

	initial begin
		csa_catch_t cnt;
		logic [csa_data_w-1:0] rd;
		int errs;
		void'($urandom(43));
		axi_mm_clk = 1'b0;
		rst_n = 1'b0;
		wen_i = 1'b0;
		waddr_i = '0;
		wdata_i = '0;
		ren_i = 1'b0;
		raddr_i = '0;
		repeat (8) @(posedge axi_mm_clk);
		@(negedge axi_mm_clk);
		rst_n = 1'b1;

		errs = err_cnt;
		write_reg(reg_channel, 2);
		read_reg(reg_channel, rd);
		check_word(rd, 2, "channel after write of 2");
		write_reg(reg_channel, unit_num);
		read_reg(reg_channel, rd);
		check_word(rd, 2, "channel after write of unit_num");
		write_reg(reg_channel, 32'hFFFF_FFFF);
		read_reg(reg_channel, rd);
		check_word(rd, 2, "channel after write of all ones");
		read_reg(reg_in_valid, rd);
		check_word(rd, 0, "in valid before any job");
		read_reg(reg_out_valid, rd);
		check_word(rd, 0, "out valid before any job");
		finish_test("channel select", errs);

		errs = err_cnt;
		queue_jobs(jobs_per_test);
		wait_bursts(jobs_per_test);
		finish_test("job results", errs);

		errs = err_cnt;
		queue_jobs(jobs_per_test);
		bp_en = 1'b1;
		wait_bursts(2 * jobs_per_test);
		bp_en = 1'b0;
		repeat (20) @(negedge axi_mm_clk); // a duplicated burst would show up here
		finish_test("back-pressure", errs);

		errs = err_cnt;
		read_reg(reg_in_valid, rd);
		check_word(rd, 1, "in valid after jobs");
		read_reg(reg_out_valid, rd);
		check_word(rd, 1, "out valid after jobs");
		for (int i = 0; i < 5; i++) begin
			read_reg(reg_in_data_0 + i, rd);
			check_word(rd, result_word(mirror_exp, i), $sformatf("in mirror word %0d", i));
		end
		for (int i = 0; i < 7; i++) begin
			read_reg(reg_out_data_0 + i, rd);
			check_word(rd, result_word(mirror_exp, i), $sformatf("out mirror word %0d", i));
		end
		write_reg(reg_channel, 2);
		read_reg(reg_in_valid, rd);
		check_word(rd, 0, "in valid after channel write");
		read_reg(reg_out_valid, rd);
		check_word(rd, 0, "out valid after channel write");
		finish_test("channel mirrors", errs);

		errs = err_cnt;
		for (int b = 0; b < 256; b++) begin
			read_count(b, cnt);
			check_count(cnt, csa_catch_t'(hist_exp[b]), $sformatf("bin %0d", b));
		end
		finish_test("histogram", errs);

		errs = err_cnt;
		write_reg(reg_clear, 1);
		repeat (2) @(negedge axi_mm_clk);
		for (int b = 0; b < 256; b++) begin
			read_count(b, cnt);
			check_count(cnt, '0, $sformatf("bin %0d after clear", b));
		end
		finish_test("soft clear", errs);

		errs = err_cnt;
		read_reg(10'd19, rd);
		check_word(rd, 32'hE000_0013, "unmapped read at 19");
		read_reg(10'd1000, rd);
		check_word(rd, 32'hE000_03E8, "unmapped read at 1000");
		finish_test("unmapped read", errs);

		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_cnt, test_fail, check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		repeat (timeout_cycles) @(posedge axi_mm_clk);
		$display("watchdog expired after %0d cycles, the run did not finish", timeout_cycles);
		$display("Regression failed");
		$finish;
	end

endmodule

// ==== project.f ====
hw/csa_pkg.sv
hw/csa_catch_hist.sv
hw/csa_trial_unit.sv
hw/csa_job_dispatch.sv
hw/csa_result_collect.sv
hw/csa_regfile.sv
hw/csa_brute_top.sv
tests/csa_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	-f project.f --top-module csa_tb -o csa_sim

./obj_dir/csa_sim | tee sim.log

if grep -q "Regression failed" sim.log; then
	echo "simulation reported a failure, see sim.log"
	exit 1
fi
if ! grep -q "Regression passed" sim.log; then
	echo "simulation ended without a result, see sim.log"
	exit 1
fi
echo "simulation passed"
